// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the matrix multiply testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mm_top -f src.f

out=$(./obj_dir/Vtb_mm_top 2>&1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -qxF "=== PASS ==="; then
  exit 0
else
  exit 1
fi

// ==== src.f ====
verilog/mm_pkg.sv
verilog/mem_port_if.sv
verilog/mm_cfg_regs.sv
verilog/mm_ctrl.sv
verilog/mm_mem_arbiter.sv
verilog/mm_operand_loader.sv
verilog/mm_mac_engine.sv
verilog/mm_z_storer.sv
verilog/mm_top.sv
test/tb_mm_mem.sv
test/tb_mm_top.sv

// ==== test/tb_mm_mem.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Testbench memory model
// Random grant stalls, one-cycle read latency, backdoor writes
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_mm_mem #(
  parameter int SEED = 1
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  logic                      we_i,
  input  logic [mm_pkg::ADDR_W-1:0] addr_i,
  input  logic [mm_pkg::DATA_W-1:0] wdata_i,
  output logic                      gnt_o,
  output logic                      rvalid_o,
  output logic [mm_pkg::DATA_W-1:0] rdata_o,
  input  logic                      bd_we_i,
  input  logic [mm_pkg::ADDR_W-1:0] bd_addr_i,
  input  logic [mm_pkg::DATA_W-1:0] bd_wdata_i
);
  import mm_pkg::*;

  localparam int WORDS = 2 ** (ADDR_W - 2);

  logic [DATA_W-1:0] words [0:WORDS-1];
  integer            seed;

  initial begin
    seed = SEED;
    // Fill pattern ties every word to its own address
    for (int i = 0; i < WORDS; i++) begin
      words[i] = {16'(i) ^ 16'hc3a5, ~16'(i)};
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
      rdata_o  <= '0;
    end else begin
      // Grant about three cycles in four
      gnt_o    <= (($random(seed) & 3) != 0);
      rvalid_o <= req_i & gnt_o & ~we_i;
      if (req_i && gnt_o && !we_i) begin
        rdata_o <= words[addr_i[ADDR_W-1:2]];
      end
    end
  end

  always @(posedge clk_i) begin
    if (bd_we_i) begin
      words[bd_addr_i[ADDR_W-1:2]] <= bd_wdata_i;
    end else if (req_i && gnt_o && we_i) begin
      words[addr_i[ADDR_W-1:2]] <= wdata_i;
    end
  end

endmodule

`default_nettype wire

// ==== test/tb_mm_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Matrix multiply accelerator testbench
// Directed jobs checked against a reference product
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module tb_mm_top;
  import mm_pkg::*;

  localparam int SEED   = 36194;
  localparam int WORD_W = ADDR_W - 2;

  logic                 clk;
  logic                 rst_n;
  logic                 periph_req;
  logic                 periph_we;
  logic [REG_IDX_W-1:0] periph_addr;
  logic [DATA_W-1:0]    periph_wdata;
  logic [DATA_W-1:0]    periph_rdata;
  logic                 busy;
  logic                 evt;
  logic                 mem_req;
  logic                 mem_we;
  logic [ADDR_W-1:0]    mem_addr;
  logic [DATA_W-1:0]    mem_wdata;
  logic                 mem_gnt;
  logic                 mem_rvalid;
  logic [DATA_W-1:0]    mem_rdata;
  logic                 bd_we;
  logic [ADDR_W-1:0]    bd_addr;
  logic [DATA_W-1:0]    bd_wdata;

  integer            seed;
  int                evt_cnt;
  int                z_lo;
  int                z_hi;
  logic              busy_prev;
  logic [DATA_W-1:0] xs [0:15];
  logic [DATA_W-1:0] ws [0:K_DIM-1];

  mm_top dut (
    .clk_i(clk), .rst_ni(rst_n), .periph_req_i(periph_req), .periph_we_i(periph_we),
    .periph_addr_i(periph_addr), .periph_wdata_i(periph_wdata),
    .periph_rdata_o(periph_rdata), .busy_o(busy), .evt_o(evt), .mem_req_o(mem_req),
    .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .mem_gnt_i(mem_gnt), .mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata)
  );

  tb_mm_mem #(.SEED(SEED)) i_mem (
    .clk_i(clk), .rst_ni(rst_n), .req_i(mem_req), .we_i(mem_we), .addr_i(mem_addr),
    .wdata_i(mem_wdata), .gnt_o(mem_gnt), .rvalid_o(mem_rvalid), .rdata_o(mem_rdata),
    .bd_we_i(bd_we), .bd_addr_i(bd_addr), .bd_wdata_i(bd_wdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_eq(string name, logic [DATA_W-1:0] got, logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got %h, expected %h", name, got, exp);
      stop_run();
    end
  endtask

  always @(posedge clk) begin
    // Count done events, busy must drop in the cycle of each one
    if (rst_n && evt) begin
      evt_cnt <= evt_cnt + 1;
      check_eq("busy_o before evt_o", 32'(busy_prev), 32'd1);
      check_eq("busy_o at evt_o", 32'(busy), 32'd0);
    end
    busy_prev <= busy;
    // Only the current Z area may be written
    if (mem_req && mem_gnt && mem_we && (int'(mem_addr) < z_lo || int'(mem_addr) >= z_hi)) begin
      $display("Memory write at address %h lies outside the Z area", mem_addr);
      stop_run();
    end
  end

  // Z[r][j] is the sum over k of signed X byte k times signed W row k byte j
  function automatic logic [DATA_W-1:0] ref_z(int r, int j);
    logic signed [DATA_W-1:0] acc;
    logic signed [7:0]        a;
    logic signed [7:0]        b;
    acc = '0;
    for (int k = 0; k < K_DIM; k++) begin
      a   = xs[r][8*k +: 8];
      b   = ws[k][8*j +: 8];
      acc = acc + (32'(a) * 32'(b));
    end
    return acc;
  endfunction

  function automatic logic [DATA_W-1:0] mem_word(int byte_addr);
    return i_mem.words[WORD_W'(byte_addr >> 2)];
  endfunction

  task automatic reg_write(logic [REG_IDX_W-1:0] idx, logic [DATA_W-1:0] val);
    @(posedge clk);
    periph_req   <= 1'b1;
    periph_we    <= 1'b1;
    periph_addr  <= idx;
    periph_wdata <= val;
    @(posedge clk);
    periph_req <= 1'b0;
    periph_we  <= 1'b0;
  endtask

  task automatic reg_read(logic [REG_IDX_W-1:0] idx, output logic [DATA_W-1:0] val);
    @(posedge clk);
    periph_req  <= 1'b1;
    periph_we   <= 1'b0;
    periph_addr <= idx;
    @(posedge clk);
    periph_req <= 1'b0;
    @(negedge clk);
    val = periph_rdata;
  endtask

  task automatic mem_poke(int byte_addr, logic [DATA_W-1:0] val);
    @(posedge clk);
    bd_we    <= 1'b1;
    bd_addr  <= ADDR_W'(byte_addr);
    bd_wdata <= val;
    @(posedge clk);
    bd_we <= 1'b0;
  endtask

  task automatic random_operands(int m);
    for (int k = 0; k < K_DIM; k++) begin
      ws[k] = $random(seed);
    end
    for (int r = 0; r < m; r++) begin
      xs[r] = $random(seed);
    end
  endtask

  task automatic wait_evt(int ev0);
    int n;
    n = 0;
    while (evt_cnt == ev0 && n < 4000) begin
      @(negedge clk);
      n++;
    end
    if (evt_cnt == ev0) begin
      $display("Timeout: no done event within %0d cycles of the trigger", n);
      stop_run();
    end
  endtask

  task automatic run_job(int x_base, int w_base, int z_base, int m, bit retrigger);
    int                ev0;
    logic [DATA_W-1:0] status;
    for (int k = 0; k < K_DIM; k++) begin
      mem_poke(w_base + 4 * k, ws[k]);
    end
    for (int r = 0; r < m; r++) begin
      mem_poke(x_base + 4 * r, xs[r]);
    end
    reg_write(REG_X_ADDR, 32'(x_base));
    reg_write(REG_W_ADDR, 32'(w_base));
    reg_write(REG_Z_ADDR, 32'(z_base));
    reg_write(REG_M_ROWS, 32'(m));
    z_lo = z_base;
    z_hi = z_base + 16 * m;
    ev0  = evt_cnt;
    reg_write(REG_TRIGGER, 32'd1);
    // Busy is up one cycle after the trigger write
    @(negedge clk);
    check_eq("busy_o", 32'(busy), 32'd1);
    if (retrigger) begin
      reg_read(REG_STATUS, status);
      check_eq("status_busy", status, 32'd1);
      // Ignored while the first job runs
      reg_write(REG_TRIGGER, 32'd1);
    end
    wait_evt(ev0);
    repeat (40) @(negedge clk);
    check_eq("evt_count", 32'(evt_cnt), 32'(ev0 + 1));
    reg_read(REG_STATUS, status);
    check_eq("status_idle", status, 32'd0);
    for (int r = 0; r < m; r++) begin
      for (int j = 0; j < K_DIM; j++) begin
        check_eq("z_word", mem_word(z_base + 16 * r + 4 * j), ref_z(r, j));
      end
    end
    z_hi = z_lo;
  endtask

  task automatic test_regs();
    logic [DATA_W-1:0] val;
    reg_read(REG_STATUS, val);
    check_eq("status", val, 32'd0);
    reg_write(REG_X_ADDR, 32'hdead1234);
    reg_write(REG_W_ADDR, 32'h00000abc);
    reg_write(REG_Z_ADDR, 32'h0000f000);
    reg_write(REG_M_ROWS, 32'h00000107);
    reg_read(REG_X_ADDR, val);
    check_eq("x_addr", val, 32'h00001234);
    reg_read(REG_W_ADDR, val);
    check_eq("w_addr", val, 32'h00000abc);
    reg_read(REG_Z_ADDR, val);
    check_eq("z_addr", val, 32'h0000f000);
    reg_read(REG_M_ROWS, val);
    check_eq("m_rows", val, 32'h00000007);
  endtask

  task automatic test_single_row();
    ws[0] = 32'h04030201;
    ws[1] = 32'h80ff7f02;
    ws[2] = 32'hfe10e0ff;
    ws[3] = 32'h01fd0380;
    xs[0] = 32'h7f80ff03;
    run_job(32'h0100, 32'h0200, 32'h0300, 1, 1'b0);
  endtask

  task automatic test_eight_rows();
    random_operands(8);
    run_job(32'h1000, 32'h1100, 32'h2000, 8, 1'b0);
  endtask

  task automatic test_busy_retrigger();
    random_operands(4);
    run_job(32'h3000, 32'h3100, 32'h3200, 4, 1'b1);
  endtask

  task automatic test_back_to_back();
    random_operands(3);
    run_job(32'h4000, 32'h4100, 32'h4200, 3, 1'b0);
    random_operands(2);
    run_job(32'h5000, 32'h5100, 32'h5200, 0, 1'b0);
    random_operands(5);
    run_job(32'h6000, 32'h6040, 32'h6100, 5, 1'b0);
  endtask

  initial begin
    seed         = SEED;
    rst_n        = 1'b0;
    periph_req   = 1'b0;
    periph_we    = 1'b0;
    periph_addr  = '0;
    periph_wdata = '0;
    bd_we        = 1'b0;
    bd_addr      = '0;
    bd_wdata     = '0;
    evt_cnt      = 0;
    z_lo         = 0;
    z_hi         = 0;
    busy_prev    = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_regs();
    test_single_row();
    test_eight_rows();
    test_busy_retrigger();
    test_back_to_back();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/mem_port_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Memory request port
// Request and grant with one-cycle read response
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

interface mem_port_if;
  import mm_pkg::*;

  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic              gnt;
  logic              rvalid;
  logic [DATA_W-1:0] rdata;

  modport master (output req, we, addr, wdata, input gnt, rvalid, rdata);
  modport slave  (input req, we, addr, wdata, output gnt, rvalid, rdata);

endinterface

`default_nettype wire

// ==== verilog/mm_cfg_regs.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Peripheral register file
// Holds the job setup, starts jobs and reports busy and done
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mm_cfg_regs (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         periph_req_i,
  input  logic                         periph_we_i,
  input  logic [mm_pkg::REG_IDX_W-1:0] periph_addr_i,
  input  logic [mm_pkg::DATA_W-1:0]    periph_wdata_i,
  output logic [mm_pkg::DATA_W-1:0]    periph_rdata_o,
  input  logic                         done_i,
  output mm_pkg::mm_cfg_t              cfg_o,
  output logic                         start_o,
  output logic                         busy_o,
  output logic                         evt_o
);
  import mm_pkg::*;

  mm_cfg_t           cfg_q;
  logic              busy_q;
  logic              evt_q;
  logic              wr_en;
  logic              trig;
  logic [DATA_W-1:0] rdata_q;
  logic [DATA_W-1:0] rd_mux;

  assign wr_en = periph_req_i & periph_we_i;
  // Trigger is dropped while a job runs
  assign trig  = wr_en & (periph_addr_i == REG_TRIGGER) & ~busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q  <= '0;
      busy_q <= 1'b0;
      evt_q  <= 1'b0;
    end else begin
      evt_q <= done_i;
      if (done_i) begin
        busy_q <= 1'b0;
      end else if (trig) begin
        busy_q <= 1'b1;
      end
      if (wr_en) begin
        case (periph_addr_i)
          REG_X_ADDR: cfg_q.x_base <= periph_wdata_i[ADDR_W-1:0];
          REG_W_ADDR: cfg_q.w_base <= periph_wdata_i[ADDR_W-1:0];
          REG_Z_ADDR: cfg_q.z_base <= periph_wdata_i[ADDR_W-1:0];
          REG_M_ROWS: cfg_q.m_rows <= periph_wdata_i[ROWS_W-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (periph_addr_i)
      REG_X_ADDR: rd_mux = DATA_W'(cfg_q.x_base);
      REG_W_ADDR: rd_mux = DATA_W'(cfg_q.w_base);
      REG_Z_ADDR: rd_mux = DATA_W'(cfg_q.z_base);
      REG_M_ROWS: rd_mux = DATA_W'(cfg_q.m_rows);
      REG_STATUS: rd_mux = DATA_W'(busy_q);
      default:    rd_mux = '0;
    endcase
  end

  // Read data lands one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (periph_req_i && !periph_we_i) begin
      rdata_q <= rd_mux;
    end
  end

  assign periph_rdata_o = rdata_q;
  assign cfg_o          = cfg_q;
  assign start_o        = trig;
  assign busy_o         = busy_q;
  assign evt_o          = evt_q;

endmodule

`default_nettype wire

// ==== verilog/mm_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Job controller
// Sequences weight load, row issue, store drain and finish
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mm_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  mm_pkg::mm_cfg_t           cfg_i,
  input  logic                      w_done_i,
  input  logic                      z_taken_i,
  input  logic                      z_stored_i,
  output logic                      load_w_o,
  output logic                      row_load_o,
  output logic [mm_pkg::ROWS_W-1:0] row_idx_o,
  output logic                      done_o,
  output logic                      flush_o
);
  import mm_pkg::*;

  mm_state_e         state_q;
  mm_state_e         state_d;
  logic [ROWS_W-1:0] issued_q;
  logic [ROWS_W-1:0] issued_d;
  logic [ROWS_W-1:0] stored_q;
  logic [ROWS_W-1:0] stored_d;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      issued_q <= '0;
      stored_q <= '0;
    end else begin
      state_q  <= state_d;
      issued_q <= issued_d;
      stored_q <= stored_d;
    end
  end

  // Next row to fetch is always the issued count
  assign row_idx_o = issued_q;

  always_comb begin
    state_d    = state_q;
    issued_d   = issued_q;
    stored_d   = stored_q + ROWS_W'(z_stored_i);
    load_w_o   = 1'b0;
    row_load_o = 1'b0;
    done_o     = 1'b0;
    flush_o    = 1'b0;

    case (state_q)
      IDLE: begin
        issued_d = '0;
        stored_d = '0;
        if (start_i) begin
          load_w_o = 1'b1;
          state_d  = LOAD_W;
        end
      end

      LOAD_W: begin
        if (w_done_i) begin
          if (cfg_i.m_rows == '0) begin
            state_d = FINISHED;
          end else begin
            row_load_o = 1'b1;
            issued_d   = issued_q + 1'b1;
            state_d    = COMPUTE;
          end
        end
      end

      // Next row goes out once the storer has taken the current one
      COMPUTE: begin
        if (z_taken_i) begin
          if (issued_q == cfg_i.m_rows) begin
            state_d = STORE_WAIT;
          end else begin
            row_load_o = 1'b1;
            issued_d   = issued_q + 1'b1;
          end
        end
      end

      STORE_WAIT: begin
        if (stored_d == cfg_i.m_rows) begin
          state_d = FINISHED;
        end
      end

      FINISHED: begin
        done_o  = 1'b1;
        flush_o = 1'b1;
        state_d = IDLE;
      end

      default: state_d = IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== verilog/mm_mac_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// MAC engine
// Multiplies one X row by the stored W into a Z row
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mm_mac_engine (
  input  logic                                            clk_i,
  input  logic                                            rst_ni,
  input  logic                                            flush_i,
  input  logic                                            w_we_i,
  input  logic [mm_pkg::K_IDX_W-1:0]                      w_idx_i,
  input  logic [mm_pkg::DATA_W-1:0]                       w_data_i,
  input  logic                                            x_valid_i,
  input  logic [mm_pkg::DATA_W-1:0]                       x_data_i,
  input  logic                                            z_ready_i,
  output logic                                            z_valid_o,
  output logic [mm_pkg::K_DIM-1:0][mm_pkg::DATA_W-1:0]    z_row_o
);
  import mm_pkg::*;

  logic [K_DIM-1:0][DATA_W-1:0]        w_q;
  logic [K_DIM-1:0][DATA_W-1:0]        z_q;
  logic signed [K_DIM-1:0][DATA_W-1:0] sum;
  logic                                z_valid_q;

  // W word k is row k and byte j of it is column j
  always_ff @(posedge clk_i) begin
    if (flush_i) begin
      w_q <= '0;
    end else if (w_we_i) begin
      w_q[w_idx_i] <= w_data_i;
    end
  end

  always_comb begin
    logic signed [ELEM_W-1:0]   x_elem;
    logic signed [ELEM_W-1:0]   w_elem;
    logic signed [2*ELEM_W-1:0] prod;
    for (int j = 0; j < K_DIM; j++) begin
      sum[j] = '0;
      for (int k = 0; k < K_DIM; k++) begin
        x_elem = x_data_i[ELEM_W*k +: ELEM_W];
        w_elem = w_q[k][ELEM_W*j +: ELEM_W];
        prod   = (2*ELEM_W)'(x_elem) * (2*ELEM_W)'(w_elem);
        sum[j] = $signed(sum[j]) + DATA_W'(prod);
      end
    end
  end

  // Result is held until the storer accepts it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      z_valid_q <= 1'b0;
    end else if (x_valid_i) begin
      z_valid_q <= 1'b1;
    end else if (z_ready_i) begin
      z_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (x_valid_i) begin
      z_q <= sum;
    end
  end

  assign z_valid_o = z_valid_q;
  assign z_row_o   = z_q;

endmodule

`default_nettype wire

// ==== verilog/mm_mem_arbiter.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Memory port arbiter
// Storer wins over loader, read data returns to its issuer
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mm_mem_arbiter (
  input  logic       clk_i,
  input  logic       rst_ni,
  mem_port_if.slave  ld,
  mem_port_if.slave  st,
  mem_port_if.master mem
);

  logic owner_st_q;

  assign mem.req   = ld.req | st.req;
  assign mem.we    = st.req ? st.we    : ld.we;
  assign mem.addr  = st.req ? st.addr  : ld.addr;
  assign mem.wdata = st.req ? st.wdata : ld.wdata;

  assign st.gnt = mem.gnt & st.req;
  assign ld.gnt = mem.gnt & ld.req & ~st.req;

  // Remember who issued the last accepted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owner_st_q <= 1'b0;
    end else if (mem.req && mem.gnt && !mem.we) begin
      owner_st_q <= st.req;
    end
  end

  assign st.rvalid = mem.rvalid & owner_st_q;
  assign ld.rvalid = mem.rvalid & ~owner_st_q;
  assign st.rdata  = mem.rdata;
  assign ld.rdata  = mem.rdata;

endmodule

`default_nettype wire

// ==== verilog/mm_operand_loader.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Operand loader
// Reads the W rows into the engine and one X row per command
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mm_operand_loader (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  mm_pkg::mm_cfg_t            cfg_i,
  input  logic                       load_w_i,
  input  logic                       row_load_i,
  input  logic [mm_pkg::ROWS_W-1:0]  row_idx_i,
  mem_port_if.master                 mem,
  output logic                       w_we_o,
  output logic [mm_pkg::K_IDX_W-1:0] w_idx_o,
  output logic [mm_pkg::DATA_W-1:0]  w_data_o,
  output logic                       w_done_o,
  output logic                       x_valid_o,
  output logic [mm_pkg::DATA_W-1:0]  x_data_o
);
  import mm_pkg::*;

  logic               req_q;
  logic               w_mode_q;
  logic [K_IDX_W-1:0] cnt_q;
  logic [ADDR_W-1:0]  addr_q;
  logic               w_last;

  assign w_last = (cnt_q == K_IDX_W'(K_DIM - 1));

  // One read in flight, next W word is requested after its predecessor returns
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q    <= 1'b0;
      w_mode_q <= 1'b0;
      cnt_q    <= '0;
    end else if (load_w_i) begin
      req_q    <= 1'b1;
      w_mode_q <= 1'b1;
      cnt_q    <= '0;
    end else if (row_load_i) begin
      req_q    <= 1'b1;
      w_mode_q <= 1'b0;
    end else if (req_q && mem.gnt) begin
      req_q <= 1'b0;
    end else if (mem.rvalid && w_mode_q) begin
      cnt_q <= cnt_q + 1'b1;
      req_q <= ~w_last;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_w_i) begin
      addr_q <= cfg_i.w_base;
    end else if (row_load_i) begin
      addr_q <= cfg_i.x_base + ADDR_W'({row_idx_i, 2'b00});
    end else if (mem.rvalid && w_mode_q) begin
      addr_q <= addr_q + ADDR_W'(4);
    end
  end

  assign mem.req   = req_q;
  assign mem.we    = 1'b0;
  assign mem.addr  = addr_q;
  assign mem.wdata = '0;

  assign w_we_o    = mem.rvalid & w_mode_q;
  assign w_idx_o   = cnt_q;
  assign w_data_o  = mem.rdata;
  assign w_done_o  = mem.rvalid & w_mode_q & w_last;
  assign x_valid_o = mem.rvalid & ~w_mode_q;
  assign x_data_o  = mem.rdata;

endmodule

`default_nettype wire

// ==== verilog/mm_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Matrix multiply accelerator shared definitions
// Sizes, register map, controller states and job configuration
// ~~~~~~~~~~~~~~~~~~~~

`default_nettype none

package mm_pkg;

  // Memory geometry
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;

  // Matrix geometry
  localparam int unsigned K_DIM   = 4;
  localparam int unsigned K_IDX_W = $clog2(K_DIM);
  localparam int unsigned ELEM_W  = 8;
  localparam int unsigned ROWS_W  = 8;

  // Peripheral register map
  localparam int unsigned REG_IDX_W = 3;
  localparam logic [REG_IDX_W-1:0] REG_X_ADDR  = 3'd0;
  localparam logic [REG_IDX_W-1:0] REG_W_ADDR  = 3'd1;
  localparam logic [REG_IDX_W-1:0] REG_Z_ADDR  = 3'd2;
  localparam logic [REG_IDX_W-1:0] REG_M_ROWS  = 3'd3;
  localparam logic [REG_IDX_W-1:0] REG_TRIGGER = 3'd4;
  localparam logic [REG_IDX_W-1:0] REG_STATUS  = 3'd5;

  typedef enum logic [2:0] {
    IDLE,
    LOAD_W,
    COMPUTE,
    STORE_WAIT,
    FINISHED
  } mm_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] x_base;
    logic [ADDR_W-1:0] w_base;
    logic [ADDR_W-1:0] z_base;
    logic [ROWS_W-1:0] m_rows;
  } mm_cfg_t;

endpackage

`default_nettype wire

// ==== verilog/mm_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Matrix multiply accelerator top
// Computes Z = X * W from a shared memory under host control
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mm_top (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         periph_req_i,
  input  logic                         periph_we_i,
  input  logic [mm_pkg::REG_IDX_W-1:0] periph_addr_i,
  input  logic [mm_pkg::DATA_W-1:0]    periph_wdata_i,
  output logic [mm_pkg::DATA_W-1:0]    periph_rdata_o,
  output logic                         busy_o,
  output logic                         evt_o,
  output logic                         mem_req_o,
  output logic                         mem_we_o,
  output logic [mm_pkg::ADDR_W-1:0]    mem_addr_o,
  output logic [mm_pkg::DATA_W-1:0]    mem_wdata_o,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rvalid_i,
  input  logic [mm_pkg::DATA_W-1:0]    mem_rdata_i
);
  import mm_pkg::*;

  mm_cfg_t                      cfg;
  logic                         start, done, flush;
  logic                         load_w, row_load, w_done;
  logic [ROWS_W-1:0]            row_idx;
  logic                         w_we, x_valid;
  logic [K_IDX_W-1:0]           w_idx;
  logic [DATA_W-1:0]            w_data, x_data;
  logic                         z_valid, z_ready, z_taken, z_stored;
  logic [K_DIM-1:0][DATA_W-1:0] z_row;

  mem_port_if ld_port ();
  mem_port_if st_port ();
  mem_port_if mem_port ();

  assign z_taken = z_valid & z_ready;

  mm_cfg_regs i_cfg_regs (
    .clk_i, .rst_ni, .periph_req_i, .periph_we_i, .periph_addr_i, .periph_wdata_i,
    .periph_rdata_o, .done_i(done), .cfg_o(cfg), .start_o(start), .busy_o, .evt_o
  );

  mm_ctrl i_ctrl (
    .clk_i, .rst_ni, .start_i(start), .cfg_i(cfg), .w_done_i(w_done),
    .z_taken_i(z_taken), .z_stored_i(z_stored), .load_w_o(load_w),
    .row_load_o(row_load), .row_idx_o(row_idx), .done_o(done), .flush_o(flush)
  );

  mm_operand_loader i_loader (
    .clk_i, .rst_ni, .cfg_i(cfg), .load_w_i(load_w), .row_load_i(row_load),
    .row_idx_i(row_idx), .mem(ld_port), .w_we_o(w_we), .w_idx_o(w_idx),
    .w_data_o(w_data), .w_done_o(w_done), .x_valid_o(x_valid), .x_data_o(x_data)
  );

  mm_mac_engine i_engine (
    .clk_i, .rst_ni, .flush_i(flush), .w_we_i(w_we), .w_idx_i(w_idx), .w_data_i(w_data),
    .x_valid_i(x_valid), .x_data_i(x_data), .z_ready_i(z_ready),
    .z_valid_o(z_valid), .z_row_o(z_row)
  );

  mm_z_storer i_storer (
    .clk_i, .rst_ni, .flush_i(flush), .cfg_i(cfg), .z_valid_i(z_valid), .z_row_i(z_row),
    .z_ready_o(z_ready), .z_stored_o(z_stored), .mem(st_port)
  );

  mm_mem_arbiter i_arbiter (
    .clk_i, .rst_ni, .ld(ld_port), .st(st_port), .mem(mem_port)
  );

  // Shared memory port to the pins
  assign mem_req_o       = mem_port.req;
  assign mem_we_o        = mem_port.we;
  assign mem_addr_o      = mem_port.addr;
  assign mem_wdata_o     = mem_port.wdata;
  assign mem_port.gnt    = mem_gnt_i;
  assign mem_port.rvalid = mem_rvalid_i;
  assign mem_port.rdata  = mem_rdata_i;

endmodule

`default_nettype wire

// ==== verilog/mm_z_storer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Z row storer
// Buffers one result row and writes its four words
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps
`default_nettype none

module mm_z_storer (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         flush_i,
  input  mm_pkg::mm_cfg_t                              cfg_i,
  input  logic                                         z_valid_i,
  input  logic [mm_pkg::K_DIM-1:0][mm_pkg::DATA_W-1:0] z_row_i,
  output logic                                         z_ready_o,
  output logic                                         z_stored_o,
  mem_port_if.master                                   mem
);
  import mm_pkg::*;

  logic                         busy_q;
  logic                         stored_q;
  logic [K_IDX_W-1:0]           cnt_q;
  logic [ROWS_W-1:0]            row_q;
  logic [K_DIM-1:0][DATA_W-1:0] buf_q;
  logic                         take;
  logic                         last_write;

  assign take       = z_valid_i & ~busy_q;
  assign last_write = busy_q & mem.gnt & (cnt_q == K_IDX_W'(K_DIM - 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      stored_q <= 1'b0;
      cnt_q    <= '0;
      row_q    <= '0;
    end else begin
      stored_q <= last_write;
      // Row numbering restarts with every job
      if (flush_i) begin
        busy_q <= 1'b0;
        cnt_q  <= '0;
        row_q  <= '0;
      end else if (take) begin
        busy_q <= 1'b1;
        cnt_q  <= '0;
      end else if (busy_q && mem.gnt) begin
        cnt_q <= cnt_q + 1'b1;
        if (last_write) begin
          busy_q <= 1'b0;
          row_q  <= row_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (flush_i) begin
      buf_q <= '0;
    end else if (take) begin
      buf_q <= z_row_i;
    end
  end

  assign mem.req   = busy_q;
  assign mem.we    = 1'b1;
  assign mem.addr  = cfg_i.z_base + ADDR_W'({row_q, 4'b0000}) + ADDR_W'({cnt_q, 2'b00});
  assign mem.wdata = buf_q[cnt_q];

  assign z_ready_o  = ~busy_q;
  assign z_stored_o = stored_q;

endmodule

`default_nettype wire
